//--- rtl/tpu_params.svh
// Global sizing for the matrix engine external access port
// Included by the packages and by any module that needs the raw numbers
// Word and address widths here set the shared memory geometry

`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define TPU_DATA_WIDTH	32			// One data word
`define TPU_ADDR_WIDTH	8			// 256 words of shared memory

//////////////////////////////
// Host port
//////////////////////////////

// Store buffer depth, also the longest legal request
`define TPU_BUFF_SIZE	16

// Marker sent back once a store has fully landed in memory
`define TPU_NOTIFY_WORD	32'h5A5A_0D0E

`endif

//--- rtl/pkg_tpu.sv
// Engine-side types shared by the host port handler and the address generators
// Word, address and the strided access configuration live here

`include "tpu_params.svh"

package pkg_tpu;

	// One word on the host port and in memory
	typedef logic [`TPU_DATA_WIDTH-1:0]	data_t;

	// Word address into the shared memory
	typedef logic [`TPU_ADDR_WIDTH-1:0]	address_t;

	// Strided access, decoded from the request header
	typedef struct packed {
		address_t	base;			// First address
		address_t	stride;			// Added after each access
		address_t	length;			// Number of words, 1 up to buffer size
	} access_cfg_t;

	// Bit 0 of the command word
	typedef enum logic {
		CMD_STORE	= 1'b0,
		CMD_LOAD	= 1'b1
	} cmd_kind_t;

endpackage

//--- rtl/pkg_mem.sv
// Shared memory types
// Request format seen by the arbiter and the memory, plus requester naming

package pkg_mem;

	import pkg_tpu::*;

	// One access on the shared memory port
	typedef struct packed {
		logic		we;				// Set for a write
		address_t	addr;
		data_t		wdata;			// Ignored on reads
	} mem_req_t;

	// Requesters behind the arbiter
	typedef enum logic {
		PEER_STORE	= 1'b0,
		PEER_LOAD	= 1'b1
	} peer_t;

endpackage

//--- rtl/ring_buffer.sv
// Circular FIFO for any packed payload
// Head is visible whenever the buffer holds something
// Push while full and pop while empty are dropped

module ring_buffer #(
	parameter type	payload_t	= logic [31:0],
	parameter int	DEPTH		= 16
)(
	input	logic						clock,
	input	logic						reset,
	input	logic						push,
	input	payload_t					push_data,
	input	logic						pop,
	output	payload_t					head,
	output	logic						empty,
	output	logic						full,
	output	logic [$clog2(DEPTH+1)-1:0]	count
);

	localparam int	PTR_W	= (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int	CNT_W	= $clog2(DEPTH+1);

	payload_t				slots [DEPTH];
	logic	[PTR_W-1:0]		wr_ptr;
	logic	[PTR_W-1:0]		rd_ptr;
	logic					do_push;
	logic					do_pop;

	assign do_push	= push & ~full;
	assign do_pop	= pop & ~empty;

	assign empty	= (count == '0);
	assign full		= (count == CNT_W'(DEPTH));
	assign head		= slots[rd_ptr];

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			slots[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap at DEPTH, not at a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/stride_agu.sv
// Strided address generator
// Loaded by a start pulse, then requests one access per grant
// until length accesses are done. WRITE picks store or load at elaboration

module stride_agu #(
	parameter bit	WRITE	= 1'b0
)(
	input	logic					clock,
	input	logic					reset,
	input	logic					start,
	input	pkg_tpu::access_cfg_t	cfg,
	input	pkg_tpu::data_t			wdata,
	output	logic					req,
	output	pkg_mem::mem_req_t		mem_req,
	input	logic					grant,
	output	logic					term
);

	import pkg_tpu::*;

	logic			active;
	address_t		addr_r;
	address_t		stride_r;
	address_t		remain;			// Accesses still to issue

	assign req				= active;
	assign term				= grant & (remain == address_t'(1));

	assign mem_req.we		= WRITE;
	assign mem_req.addr		= addr_r;
	assign mem_req.wdata	= WRITE ? wdata : '0;

	// Control
	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			remain <= '0;
		end else if (start) begin
			active <= 1'b1;
			remain <= cfg.length;
		end else if (grant && active) begin
			remain <= remain - 1'b1;
			if (remain == address_t'(1)) active <= 1'b0;
		end
	end

	// Address walk, wraps with the address width
	always_ff @(posedge clock) begin
		if (start) begin
			addr_r   <= cfg.base;
			stride_r <= cfg.stride;
		end else if (grant && active) begin
			addr_r <= addr_r + stride_r;
		end
	end

endmodule

//--- rtl/mem_arbiter.sv
// Round-robin arbiter in front of the shared data memory
// Grants one requester per cycle; the last winner yields on a tie.
// Read data returns to the load peer one cycle after its grant

module mem_arbiter (
	input	logic					clock,
	input	logic					reset,
	input	logic					st_req,
	input	pkg_mem::mem_req_t		st_mem_req,
	input	logic					ld_req,
	input	pkg_mem::mem_req_t		ld_mem_req,
	output	logic					st_grant,
	output	logic					ld_grant,
	output	pkg_mem::mem_req_t		mem_req,
	output	logic					mem_en,
	input	pkg_tpu::data_t			rdata,
	output	logic					ld_valid,
	output	pkg_tpu::data_t			ld_data
);

	import pkg_mem::*;

	peer_t		last_win;
	logic		ld_tag;			// Load granted last cycle

	assign st_grant	= st_req & (~ld_req | (last_win == PEER_LOAD));
	assign ld_grant	= ld_req & ~st_grant;

	assign mem_en	= st_grant | ld_grant;
	assign mem_req	= st_grant ? st_mem_req : ld_mem_req;

	assign ld_valid	= ld_tag;
	assign ld_data	= rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			last_win <= PEER_LOAD;		// Store goes first on an early tie
			ld_tag   <= 1'b0;
		end else begin
			if (st_grant)      last_win <= PEER_STORE;
			else if (ld_grant) last_win <= PEER_LOAD;
			ld_tag <= ld_grant;
		end
	end

endmodule

//--- rtl/data_memory.sv
// Shared data memory, single port
// Writes land on the clock edge; reads come out one cycle later

`include "tpu_params.svh"

module data_memory (
	input	logic					clock,
	input	logic					en,
	input	pkg_mem::mem_req_t		mem_req,
	output	pkg_tpu::data_t			rdata
);

	import pkg_tpu::*;

	localparam int	WORDS	= 1 << `TPU_ADDR_WIDTH;

	data_t		mem [WORDS];

	always_ff @(posedge clock) begin
		if (en) begin
			if (mem_req.we) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end else begin
				rdata <= mem[mem_req.addr];		// Registered read
			end
		end
	end

endmodule

//--- rtl/extern_handle.sv
// Host port handler
// Decodes the four-word request header, holds the access configuration,
// buffers store data and starts the matching address generator.
// Load words and the store notify go back out on out_req / out_data

`include "tpu_params.svh"

module extern_handle (
	input	logic					clock,
	input	logic					reset,
	input	logic					in_req,
	input	pkg_tpu::data_t			in_data,
	output	logic					out_req,
	output	pkg_tpu::data_t			out_data,
	output	logic					ld_start,
	output	pkg_tpu::access_cfg_t	ld_cfg,
	input	logic					ld_valid,
	input	pkg_tpu::data_t			ld_data,
	input	logic					ld_term,
	output	logic					st_start,
	output	pkg_tpu::access_cfg_t	st_cfg,
	output	pkg_tpu::data_t			st_data,
	input	logic					st_grant,
	input	logic					st_term
);

	import pkg_tpu::*;

	typedef enum logic [2:0] {SV_IDLE, SV_STRIDE, SV_LENGTH, SV_BASE, SV_RUN} serv_t;
	typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_DRAIN, ST_NOTIFY} st_phase_t;
	typedef enum logic [1:0] {LD_IDLE, LD_RUN, LD_TAIL, LD_DONE} ld_phase_t;

	serv_t							serv;
	st_phase_t						st_phase;
	ld_phase_t						ld_phase;

	cmd_kind_t						cmd_r;
	address_t						stride_r;
	address_t						length_r;

	access_cfg_t					cfg_in;
	access_cfg_t					cfg_head;
	logic	[$clog2(`TPU_BUFF_SIZE+1)-1:0]	buf_count;
	logic							fill_push;
	logic							fill_last;
	logic							header_done;

	logic							ld_fwd_req;
	data_t							ld_fwd_data;

	assign header_done	= in_req & (serv == SV_BASE);
	assign fill_push	= in_req & (st_phase == ST_FILL);
	assign fill_last	= fill_push & (address_t'(buf_count) + 1'b1 == length_r);

	assign cfg_in		= '{base: in_data[`TPU_ADDR_WIDTH-1:0], stride: stride_r, length: length_r};
	assign ld_cfg		= cfg_head;
	assign st_cfg		= cfg_head;

	// Notify wins only in its own cycle, loads never overlap it
	assign out_req		= ld_fwd_req | (st_phase == ST_NOTIFY);
	assign out_data		= (st_phase == ST_NOTIFY) ? data_t'(`TPU_NOTIFY_WORD) : ld_fwd_data;

	//////////////////////////////
	// Header decode
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			serv <= SV_IDLE;
		end else begin
			case (serv)
				SV_IDLE:   if (in_req) serv <= SV_STRIDE;
				SV_STRIDE: if (in_req) serv <= SV_LENGTH;
				SV_LENGTH: if (in_req) serv <= SV_BASE;
				SV_BASE:   if (in_req) serv <= SV_RUN;
				SV_RUN: begin
					if (st_term || ld_phase == LD_DONE) serv <= SV_IDLE;
				end
				default:   serv <= SV_IDLE;
			endcase
		end
	end

	// Configuration registers
	always_ff @(posedge clock) begin
		if (in_req && serv == SV_IDLE)   cmd_r    <= cmd_kind_t'(in_data[0]);
		if (in_req && serv == SV_STRIDE) stride_r <= in_data[`TPU_ADDR_WIDTH-1:0];
		if (in_req && serv == SV_LENGTH) length_r <= in_data[`TPU_ADDR_WIDTH-1:0];
	end

	// Start pulses, one cycle after the triggering word
	always_ff @(posedge clock) begin
		if (reset) begin
			ld_start <= 1'b0;
			st_start <= 1'b0;
		end else begin
			ld_start <= header_done & (cmd_r == CMD_LOAD);
			st_start <= fill_last;
		end
	end

	//////////////////////////////
	// Store side
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			st_phase <= ST_IDLE;
		end else begin
			case (st_phase)
				ST_IDLE:   if (header_done && cmd_r == CMD_STORE) st_phase <= ST_FILL;
				ST_FILL:   if (fill_last) st_phase <= ST_DRAIN;
				ST_DRAIN:  if (st_term) st_phase <= ST_NOTIFY;
				ST_NOTIFY: st_phase <= ST_IDLE;
				default:   st_phase <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Load side
	//////////////////////////////

	// Last grant seen, then its word comes back one cycle later
	always_ff @(posedge clock) begin
		if (reset) begin
			ld_phase <= LD_IDLE;
		end else begin
			case (ld_phase)
				LD_IDLE: if (header_done && cmd_r == CMD_LOAD) ld_phase <= LD_RUN;
				LD_RUN:  if (ld_term) ld_phase <= LD_TAIL;
				LD_TAIL: if (ld_valid) ld_phase <= LD_DONE;
				LD_DONE: ld_phase <= LD_IDLE;
				default: ld_phase <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_fwd_req <= 1'b0;
		end else begin
			ld_fwd_req <= ld_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (ld_valid) ld_fwd_data <= ld_data;
	end

	// Store data, head feeds the store generator's write data
	ring_buffer #(
		.payload_t	(data_t),
		.DEPTH		(`TPU_BUFF_SIZE)
	) store_buf (
		.clock		(clock),
		.reset		(reset),
		.push		(fill_push),
		.push_data	(in_data),
		.pop		(st_grant),
		.head		(st_data),
		.empty		(),
		.full		(),
		.count		(buf_count)
	);

	// Decoded configuration, released by whichever generator starts
	ring_buffer #(
		.payload_t	(access_cfg_t),
		.DEPTH		(1)
	) cfg_hold (
		.clock		(clock),
		.reset		(reset),
		.push		(header_done),
		.push_data	(cfg_in),
		.pop		(ld_start | st_start),
		.head		(cfg_head),
		.empty		(),
		.full		(),
		.count		()
	);

endmodule

//--- rtl/tpu_extern_top.sv
// External access port of the matrix engine
// Host requests run as strided loads or stores on the shared memory.
// Structural only, the handler drives both generators through one arbiter

module tpu_extern_top (
	input	logic				clock,
	input	logic				reset,
	input	logic				in_req,
	input	pkg_tpu::data_t		in_data,
	output	logic				out_req,
	output	pkg_tpu::data_t		out_data
);

	import pkg_tpu::*;
	import pkg_mem::*;

	// Handler to generators
	logic			ld_start, st_start;
	access_cfg_t	ld_cfg, st_cfg;
	data_t			st_data;

	// Generators to arbiter
	logic			ld_req, st_req;
	logic			ld_grant, st_grant;
	logic			ld_term, st_term;
	mem_req_t		ld_mem_req, st_mem_req;

	// Arbiter to memory and back
	mem_req_t		mem_req;
	logic			mem_en;
	data_t			rdata;
	logic			ld_valid;
	data_t			ld_data;

	extern_handle handler (
		.clock(clock), .reset(reset),
		.in_req(in_req), .in_data(in_data),
		.out_req(out_req), .out_data(out_data),
		.ld_start(ld_start), .ld_cfg(ld_cfg),
		.ld_valid(ld_valid), .ld_data(ld_data), .ld_term(ld_term),
		.st_start(st_start), .st_cfg(st_cfg), .st_data(st_data),
		.st_grant(st_grant), .st_term(st_term)
	);

	stride_agu #(.WRITE(1'b1)) st_agu (
		.clock(clock), .reset(reset), .start(st_start), .cfg(st_cfg),
		.wdata(st_data), .req(st_req), .mem_req(st_mem_req),
		.grant(st_grant), .term(st_term)
	);

	stride_agu #(.WRITE(1'b0)) ld_agu (
		.clock(clock), .reset(reset), .start(ld_start), .cfg(ld_cfg),
		.wdata('0), .req(ld_req), .mem_req(ld_mem_req),
		.grant(ld_grant), .term(ld_term)
	);

	mem_arbiter arbiter (
		.clock(clock), .reset(reset),
		.st_req(st_req), .st_mem_req(st_mem_req),
		.ld_req(ld_req), .ld_mem_req(ld_mem_req),
		.st_grant(st_grant), .ld_grant(ld_grant),
		.mem_req(mem_req), .mem_en(mem_en), .rdata(rdata),
		.ld_valid(ld_valid), .ld_data(ld_data)
	);

	data_memory memory (
		.clock(clock), .en(mem_en), .mem_req(mem_req), .rdata(rdata)
	);

endmodule

//--- test/tb_top.sv
// Random host-request testbench for the matrix engine external access port
// Fills the shared memory through stores, then runs directed and random
// loads and stores, checking replies against a memory model kept here

`include "tpu_params.svh"

module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	import pkg_tpu::*;

	localparam int	SEED			= 86384;
	localparam int	RESET_CYCLES	= 10;
	localparam int	SETTLE_CYCLES	= 3;		// Idle cycles to catch stray replies
	localparam int	INIT_REQS		= (1 << `TPU_ADDR_WIDTH) / `TPU_BUFF_SIZE;
	localparam int	DIRECTED_REQS	= 9;
	localparam int	RANDOM_ITERS	= 40;
	localparam int	MAX_REQS		= INIT_REQS + DIRECTED_REQS + 2 * RANDOM_ITERS;
	localparam int	CYCLE_LIMIT		= RESET_CYCLES + MAX_REQS * (4 + 2 * `TPU_BUFF_SIZE + 8);

	logic		clock;
	logic		reset;
	logic		in_req;
	data_t		in_data;
	logic		out_req;
	data_t		out_data;

	logic		in_header;					// Header words on the port
	int			run_cycles;
	data_t		model [1 << `TPU_ADDR_WIDTH];
	data_t		replies [$];

	tpu_extern_top uut (
		.clock		(clock),
		.reset		(reset),
		.in_req		(in_req),
		.in_data	(in_data),
		.out_req	(out_req),
		.out_data	(out_data)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	//////////////////////////////
	// Failure handling
	//////////////////////////////

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_data(string name, data_t exp, data_t got);
		if (exp !== got) begin
			stop_on_error($sformatf("Mismatch %s exp=%h got=%h", name, exp, got));
		end
	endtask

	task automatic check_count(string name, address_t exp, address_t got);
		if (exp !== got) begin
			stop_on_error($sformatf("Mismatch %s exp=%h got=%h", name, exp, got));
		end
	endtask

	always @(posedge clock) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= CYCLE_LIMIT) begin
			stop_on_error("Timeout, the port stopped answering before the tests ended");
		end
	end

	// Reply monitor on the falling edge
	always @(negedge clock) begin
		if (reset && out_req !== 1'b0) begin
			stop_on_error("out_req went high while reset was held");
		end else if (in_header && out_req) begin
			stop_on_error("out_req went high while a request header was sent");
		end else if (out_req) begin
			replies.push_back(out_data);
		end
	end

	//////////////////////////////
	// Host side
	//////////////////////////////

	task automatic send_word(data_t word, bit header);
		@(posedge clock);
		in_req    <= 1'b1;
		in_data   <= word;
		in_header <= header;
	endtask

	task automatic end_burst();
		@(posedge clock);
		in_req    <= 1'b0;
		in_header <= 1'b0;
	endtask

	// Command word carries junk above bit 0
	task automatic send_header(bit is_load, address_t stride, address_t length, address_t base);
		data_t	cmd_word;
		cmd_word    = $urandom;
		cmd_word[0] = is_load;
		send_word(cmd_word, 1'b1);
		send_word(data_t'(stride), 1'b1);
		send_word(data_t'(length), 1'b1);
		send_word(data_t'(base), 1'b1);
	endtask

	task automatic wait_replies(int n);
		while (replies.size() < n) @(posedge clock);
		repeat (SETTLE_CYCLES) @(posedge clock);
	endtask

	task automatic run_store(address_t base, address_t stride, address_t length);
		data_t		words [$];
		address_t	addr;
		for (int i = 0; i < int'(length); i++) words.push_back($urandom);
		replies.delete();
		send_header(1'b0, stride, length, base);
		foreach (words[i]) send_word(words[i], 1'b0);
		end_burst();
		addr = base;
		foreach (words[i]) begin
			model[addr] = words[i];			// Later words win on stride 0
			addr        = addr + stride;
		end
		wait_replies(1);
		check_count("store reply count", address_t'(1), address_t'(replies.size()));
		check_data("out_data notify", data_t'(`TPU_NOTIFY_WORD), replies[0]);
	endtask

	task automatic run_load(address_t base, address_t stride, address_t length);
		address_t	addr;
		replies.delete();
		send_header(1'b1, stride, length, base);
		end_burst();
		wait_replies(int'(length));
		check_count("load reply count", length, address_t'(replies.size()));
		addr = base;
		for (int i = 0; i < int'(length); i++) begin
			check_data($sformatf("out_data word %0d", i), model[addr], replies[i]);
			addr = addr + stride;
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		address_t	base;
		address_t	stride;
		address_t	length;
		void'($urandom(SEED));
		reset      <= 1'b1;
		in_req     <= 1'b0;
		in_data    <= '0;
		in_header  <= 1'b0;
		run_cycles <= 0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// Whole memory known before any load
		for (int k = 0; k < INIT_REQS; k++) begin
			run_store(address_t'(k * `TPU_BUFF_SIZE), 8'd1, 8'(`TPU_BUFF_SIZE));
		end

		run_store(8'hF8, 8'd1, 8'(`TPU_BUFF_SIZE));		// Crosses 255
		run_load(8'hF8, 8'd1, 8'(`TPU_BUFF_SIZE));
		run_store(8'h40, 8'd0, 8'd5);
		run_load(8'h40, 8'd0, 8'd4);
		run_store(8'h10, 8'd7, 8'd1);
		run_load(8'h10, 8'd7, 8'd1);
		run_load(8'hF0, 8'h11, 8'(`TPU_BUFF_SIZE));
		run_store(8'hFF, 8'hFF, 8'(`TPU_BUFF_SIZE));	// Walks downward
		run_load(8'hFF, 8'hFF, 8'(`TPU_BUFF_SIZE));

		for (int n = 0; n < RANDOM_ITERS; n++) begin
			base   = address_t'($urandom);
			stride = address_t'($urandom);
			length = address_t'(1 + ($urandom % `TPU_BUFF_SIZE));
			if ($urandom % 2) begin
				run_load(base, stride, length);
			end else begin
				run_store(base, stride, length);
				run_load(base, stride, length);
			end
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- src.f
+incdir+rtl
rtl/pkg_tpu.sv
rtl/pkg_mem.sv
rtl/ring_buffer.sv
rtl/stride_agu.sv
rtl/mem_arbiter.sv
rtl/data_memory.sv
rtl/extern_handle.sv
rtl/tpu_extern_top.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f src.f

./obj_dir/Vtb_top
